//--- Makefile
VERILATOR ?= verilator
TOP ?= cpu_core_tb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --assert --timing -Wno-fatal

FAIL_MSG = Done: errors found
PASS_MSG = Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define CPU_XLEN       32
`define CPU_NREGS      8
`define CPU_DMEM_WORDS 64

// Instruction word layout.
`define CPU_CLASS_HI   31
`define CPU_CLASS_LO   30
`define CPU_OPC_HI     29
`define CPU_OPC_LO     26
`define CPU_RD_HI      25
`define CPU_RD_LO      23
`define CPU_RA_HI      22
`define CPU_RA_LO      20
`define CPU_RB_HI      19
`define CPU_RB_LO      17
`define CPU_USE_IMM    16
`define CPU_IMM_HI     15
`define CPU_IMM_LO     0

`endif

//--- common/isa_pkg.sv
package isa_pkg;

	typedef enum logic [1:0] {
		CLASS_ARITH  = 2'b00,
		CLASS_BRANCH = 2'b01,
		CLASS_MEM    = 2'b10,
		CLASS_CALL   = 2'b11
	} instr_class_t;

	typedef enum logic [3:0] {
		ALU_ADD   = 4'b0000,
		ALU_ADDC  = 4'b0001,
		ALU_SUB   = 4'b0010,
		ALU_SUBC  = 4'b0011,
		ALU_LSL   = 4'b0100,
		ALU_LSR   = 4'b0101,
		ALU_AND   = 4'b0110,
		ALU_XOR   = 4'b0111,
		ALU_BIC   = 4'b1000,
		ALU_BST   = 4'b1001,
		ALU_OR    = 4'b1010,
		ALU_MOVHI = 4'b1011, // Passes op2 through.
		ALU_CMP   = 4'b1100,
		ALU_ASR   = 4'b1110,
		ALU_OP1   = 4'b1111
	} alu_opc_t;

	typedef enum logic [2:0] {
		COND_NEVER  = 3'b000,
		COND_NE     = 3'b001,
		COND_EQ     = 3'b010,
		COND_CC     = 3'b011,
		COND_CS     = 3'b100,
		COND_ALWAYS = 3'b111
	} branch_cond_t;

	typedef enum logic [1:0] {
		MEM_BYTE = 2'b00,
		MEM_HALF = 2'b01,
		MEM_WORD = 2'b10
	} mem_width_t;

	localparam int MEM_STORE_BIT = 3; // In the mem class opcode, bits 1:0 give the width.

endpackage

//--- common/pipe_pkg.sv
`include "cpu_config.svh"

package pipe_pkg;

	typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

	// First ALU operand comes from ra or from pc_plus_4.
	typedef enum logic {
		OP1_PC = 1'b0,
		OP1_RA = 1'b1
	} op1_sel_t;

	// Second ALU operand comes from rb or from the immediate.
	typedef enum logic {
		OP2_IMM = 1'b0,
		OP2_RB  = 1'b1
	} op2_sel_t;

endpackage

//--- compile.f
+incdir+common
+incdir+testbench
common/isa_pkg.sv
common/pipe_pkg.sv
decode/instr_decoder.sv
verilog/reg_file.sv
exec/exec_unit.sv
verilog/mem_writeback.sv
verilog/cpu_core.sv
testbench/cpu_core_tb.sv

//--- decode/instr_decoder.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module instr_decoder
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 instr_valid,
	input  logic [31:0]          instr,
	input  logic [`CPU_XLEN-1:0] pc_plus_4,
	input  logic [`CPU_XLEN-1:0] ra_data,
	input  logic [`CPU_XLEN-1:0] rb_data,
	output reg_idx_t             ra_idx,
	output reg_idx_t             rb_idx,
	output logic                 ex_valid,
	output logic [`CPU_XLEN-1:0] ra,
	output logic [`CPU_XLEN-1:0] rb,
	output logic [`CPU_XLEN-1:0] imm32,
	output logic [`CPU_XLEN-1:0] pc_out,
	output reg_idx_t             rd_sel,
	output logic                 update_rd,
	output alu_opc_t             alu_opc,
	output op1_sel_t             alu_op1_ra,
	output op2_sel_t             alu_op2_rb,
	output logic                 mem_load,
	output logic                 mem_store,
	output mem_width_t           mem_width,
	output branch_cond_t         branch_condition,
	output instr_class_t         instr_class,
	output logic                 is_call,
	output logic                 update_flags
);

	instr_class_t cls;
	logic [3:0] opc;
	logic [`CPU_XLEN-1:0] imm_sx;
	alu_opc_t d_opc;
	op1_sel_t d_op1;
	op2_sel_t d_op2;
	logic d_update_rd;
	logic d_update_flags;
	logic d_load;
	logic d_store;
	mem_width_t d_width;
	branch_cond_t d_cond;
	logic d_call;

	assign cls = instr_class_t'(instr[`CPU_CLASS_HI:`CPU_CLASS_LO]);
	assign opc = instr[`CPU_OPC_HI:`CPU_OPC_LO];
	assign imm_sx = {{(`CPU_XLEN-16){instr[`CPU_IMM_HI]}}, instr[`CPU_IMM_HI:`CPU_IMM_LO]};
	assign ra_idx = instr[`CPU_RA_HI:`CPU_RA_LO];
	assign rb_idx = instr[`CPU_RB_HI:`CPU_RB_LO];

	always_comb begin
		d_opc = ALU_ADD; // Mem and branch classes use the adder.
		d_op1 = OP1_RA;
		d_op2 = OP2_IMM;
		d_update_rd = 1'b0;
		d_update_flags = 1'b0;
		d_load = 1'b0;
		d_store = 1'b0;
		d_width = MEM_WORD;
		d_cond = COND_NEVER;
		d_call = 1'b0;
		case (cls)
		CLASS_ARITH: begin
			d_opc = alu_opc_t'(opc);
			d_op2 = instr[`CPU_USE_IMM] ? OP2_IMM : OP2_RB;
			d_update_rd = alu_opc_t'(opc) != ALU_CMP; // Compare only sets flags.
			d_update_flags = alu_opc_t'(opc) inside {ALU_ADD, ALU_SUB, ALU_CMP};
		end
		CLASS_MEM: begin
			d_store = opc[MEM_STORE_BIT];
			d_load = !opc[MEM_STORE_BIT];
			d_width = mem_width_t'(opc[1:0]);
			d_update_rd = !opc[MEM_STORE_BIT];
		end
		CLASS_BRANCH: begin
			d_op1 = OP1_PC;
			d_cond = branch_cond_t'(opc[2:0]);
		end
		CLASS_CALL: begin
			d_op1 = OP1_PC;
			d_cond = COND_ALWAYS;
			d_call = 1'b1;
			d_update_rd = 1'b1; // Link register gets pc_plus_4.
		end
		default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
			update_rd <= 1'b0;
			update_flags <= 1'b0;
			mem_load <= 1'b0;
			mem_store <= 1'b0;
			is_call <= 1'b0;
		end else begin
			ex_valid <= instr_valid;
			update_rd <= instr_valid && d_update_rd;
			update_flags <= instr_valid && d_update_flags;
			mem_load <= instr_valid && d_load;
			mem_store <= instr_valid && d_store;
			is_call <= instr_valid && d_call;
		end
	end

	always_ff @(posedge clk) begin
		ra <= ra_data;
		rb <= rb_data;
		imm32 <= imm_sx;
		pc_out <= pc_plus_4;
		rd_sel <= instr[`CPU_RD_HI:`CPU_RD_LO];
		alu_opc <= d_opc;
		alu_op1_ra <= d_op1;
		alu_op2_rb <= d_op2;
		mem_width <= d_width;
		branch_condition <= d_cond;
		instr_class <= cls;
	end

	a_store_no_rd: assert property (@(posedge clk) disable iff (rst)
		mem_store |-> !update_rd);

endmodule

//--- exec/exec_unit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module exec_unit
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ex_valid,
	input  logic [`CPU_XLEN-1:0] ra,
	input  logic [`CPU_XLEN-1:0] rb,
	input  logic [`CPU_XLEN-1:0] imm32,
	input  logic [`CPU_XLEN-1:0] pc_plus_4,
	input  reg_idx_t             rd_sel,
	input  logic                 update_rd,
	input  alu_opc_t             alu_opc,
	input  op1_sel_t             alu_op1_ra,
	input  op2_sel_t             alu_op2_rb,
	input  logic                 mem_load,
	input  logic                 mem_store,
	input  mem_width_t           mem_width,
	input  branch_cond_t         branch_condition,
	input  instr_class_t         instr_class,
	input  logic                 is_call,
	input  logic                 update_flags,
	output logic                 branch_valid,
	output logic                 branch_taken,
	output logic [`CPU_XLEN-1:0] branch_target,
	output logic                 mw_valid,
	output logic [`CPU_XLEN-1:0] alu_out,
	output logic                 mem_load_out,
	output logic                 mem_store_out,
	output mem_width_t           mem_width_out,
	output logic [`CPU_XLEN-1:0] wr_val,
	output logic                 wr_result,
	output reg_idx_t             rd_sel_out,
	output logic [`CPU_XLEN-1:0] mar,
	output logic [`CPU_XLEN-1:0] mdr,
	output logic                 mem_wr_en
);

	logic [`CPU_XLEN-1:0] op1;
	logic [`CPU_XLEN-1:0] op2;
	logic [`CPU_XLEN-1:0] alu_q;
	logic alu_c;
	logic alu_z;
	logic cond_met;
	logic c_flag; // Hidden status, not visible to software.
	logic z_flag;

	assign op1 = (alu_op1_ra == OP1_RA) ? ra : pc_plus_4;
	assign op2 = (alu_op2_rb == OP2_RB) ? rb : imm32;
	assign alu_z = op1 == op2;

	always_comb begin
		alu_c = 1'b0;
		alu_q = '0;
		case (alu_opc)
		ALU_ADD:   {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2};
		ALU_ADDC:  {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2} + {32'b0, c_flag};
		ALU_SUB:   {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2};
		ALU_SUBC:  {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2} + {32'b0, c_flag};
		ALU_LSL:   {alu_c, alu_q} = {1'b0, op1} << op2[4:0];
		ALU_LSR:   alu_q = op1 >> op2[4:0];
		ALU_AND:   alu_q = op1 & op2;
		ALU_XOR:   alu_q = op1 ^ op2;
		ALU_BIC:   alu_q = op1 & ~(32'd1 << op2[4:0]);
		ALU_BST:   alu_q = op1 | (32'd1 << op2[4:0]);
		ALU_OR:    alu_q = op1 | op2;
		ALU_MOVHI: alu_q = op2;
		ALU_CMP:   {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2};
		ALU_ASR:   alu_q = $signed(op1) >>> op2[4:0];
		ALU_OP1:   alu_q = op1;
		default:   alu_q = '0;
		endcase
	end

	always_comb begin
		case (branch_condition)
		COND_ALWAYS: cond_met = 1'b1;
		COND_NE:     cond_met = !z_flag;
		COND_EQ:     cond_met = z_flag;
		COND_CC:     cond_met = !c_flag;
		COND_CS:     cond_met = c_flag;
		default:     cond_met = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			c_flag <= 1'b0;
			z_flag <= 1'b0;
			branch_valid <= 1'b0;
			branch_taken <= 1'b0;
			mw_valid <= 1'b0;
			wr_result <= 1'b0;
			mem_load_out <= 1'b0;
			mem_store_out <= 1'b0;
			mem_wr_en <= 1'b0;
		end else begin
			if (update_flags) begin
				c_flag <= alu_c;
				z_flag <= alu_z;
			end
			branch_valid <= ex_valid && instr_class inside {CLASS_BRANCH, CLASS_CALL};
			branch_taken <= ex_valid && instr_class inside {CLASS_BRANCH, CLASS_CALL} && cond_met;
			mw_valid <= ex_valid;
			wr_result <= update_rd;
			mem_load_out <= mem_load;
			mem_store_out <= mem_store;
			mem_wr_en <= mem_store;
		end
	end

	always_ff @(posedge clk) begin
		alu_out <= alu_q;
		branch_target <= alu_q;
		rd_sel_out <= rd_sel;
		wr_val <= is_call ? pc_plus_4 : (mem_store ? op2 : alu_q);
		if (mem_load || mem_store) begin
			mem_width_out <= mem_width;
			mar <= alu_q;
			if (mem_store) begin
				mdr <= rb;
			end
		end
	end

	a_load_store_excl: assert property (@(posedge clk) disable iff (rst)
		!(mem_load && mem_store));

	a_branch_class: assert property (@(posedge clk) disable iff (rst)
		branch_valid |-> !(mem_load_out || mem_store_out));

endmodule

//--- testbench/test_table.svh
task automatic load_table;
	// Registers r5 and r6 have not been written yet.
	arith_entry("rd_zero", ALU_ADD, 7, 5, 6, 1'b0, 16'h0000, 0, 32'h0000_0000);

	// Immediate moves sign-extend the 16-bit field.
	arith_entry("mov_r1", ALU_MOVHI, 1, 0, 0, 1'b1, 16'h1234, 0, 32'h0000_1234);
	arith_entry("mov_r2", ALU_MOVHI, 2, 0, 0, 1'b1, 16'h00f0, 0, 32'h0000_00f0);
	arith_entry("mov_r3", ALU_MOVHI, 3, 0, 0, 1'b1, 16'hffff, 2, 32'hffff_ffff);

	// Independent operations issued back to back keep three in flight.
	arith_entry("add_rr", ALU_ADD, 4, 1, 2, 1'b0, 16'h0000, 0, 32'h0000_1324);
	arith_entry("sub_rr", ALU_SUB, 5, 1, 2, 1'b0, 16'h0000, 0, 32'h0000_1144);
	arith_entry("and_rr", ALU_AND, 6, 1, 2, 1'b0, 16'h0000, 0, 32'h0000_0030);
	arith_entry("or_rr", ALU_OR, 7, 1, 2, 1'b0, 16'h0000, 0, 32'h0000_12f4);
	arith_entry("xor_rr", ALU_XOR, 4, 1, 3, 1'b0, 16'h0000, 0, 32'hffff_edcb);
	arith_entry("lsl_imm", ALU_LSL, 5, 1, 0, 1'b1, 16'h0004, 0, 32'h0001_2340);
	arith_entry("lsr_imm", ALU_LSR, 6, 3, 0, 1'b1, 16'h0008, 0, 32'h00ff_ffff);
	arith_entry("bst_imm", ALU_BST, 7, 2, 0, 1'b1, 16'h001f, 0, 32'h8000_00f0);
	arith_entry("bic_imm", ALU_BIC, 4, 2, 0, 1'b1, 16'h0004, 2, 32'h0000_00e0);

	// The add overflows and leaves carry set for addc and bcs.
	arith_entry("add_carry", ALU_ADD, 5, 3, 0, 1'b1, 16'h0002, 0, 32'h0000_0001);
	arith_entry("addc", ALU_ADDC, 6, 1, 2, 1'b0, 16'h0000, 0, 32'h0000_1325);
	branch_entry("bcs_taken", COND_CS, 32'h0000_0100, 16'h0010, 0, 1'b1, 32'h0000_0110);
	branch_entry("bcc_not", COND_CC, 32'h0000_0200, 16'hfff0, 0, 1'b0, 32'h0000_01f0);
	compare_entry("cmp_eq", 1, 1, 0);
	branch_entry("beq_taken", COND_EQ, 32'h0000_0300, 16'h0040, 0, 1'b1, 32'h0000_0340);
	branch_entry("bne_not", COND_NE, 32'h0000_0304, 16'h0008, 0, 1'b0, 32'h0000_030c);
	compare_entry("cmp_ne", 1, 2, 0);
	branch_entry("bne_taken", COND_NE, 32'h0000_0400, 16'h0100, 0, 1'b1, 32'h0000_0500);
	arith_entry("sub_borrow", ALU_SUB, 7, 2, 1, 1'b0, 16'h0000, 0, 32'hffff_eebc);
	branch_entry("bcs_borrow", COND_CS, 32'h0000_0500, 16'hfffc, 0, 1'b1, 32'h0000_04fc);

	// Calls link pc_plus_4 into rd.
	call_entry("call_link", 5, 32'h0000_0600, 16'h0020, 0, 32'h0000_0620);
	branch_entry("b_always", COND_ALWAYS, 32'h0000_0700, 16'h0004, 0, 1'b1, 32'h0000_0704);
	branch_entry("b_never", COND_NEVER, 32'h0000_0704, 16'h0010, 2, 1'b0, 32'h0000_0714);

	// Base address in r1 and store data in r2.
	arith_entry("mov_base", ALU_MOVHI, 1, 0, 0, 1'b1, 16'h0040, 0, 32'h0000_0040);
	arith_entry("mov_data", ALU_MOVHI, 2, 0, 0, 1'b1, 16'h7b2c, 2, 32'h0000_7b2c);
	arith_entry("lsl_data", ALU_LSL, 2, 2, 0, 1'b1, 16'h0010, 2, 32'h7b2c_0000);
	arith_entry("or_data", ALU_OR, 2, 2, 0, 1'b1, 16'h4d5e, 2, 32'h7b2c_4d5e);
	store_entry("sw", MEM_WORD, 1, 2, 16'h0000, 0, 32'h0000_0040, 32'h7b2c_4d5e);
	store_entry("sh", MEM_HALF, 1, 2, 16'h0006, 0, 32'h0000_0046, 32'h7b2c_4d5e);
	store_entry("sb", MEM_BYTE, 1, 2, 16'h0009, 1, 32'h0000_0049, 32'h7b2c_4d5e);
	load_entry("lw", MEM_WORD, 4, 1, 16'h0000, 0, 32'h7b2c_4d5e);
	load_entry("lhu_off6", MEM_HALF, 5, 1, 16'h0006, 0, 32'h0000_4d5e);
	load_entry("lhu_off2", MEM_HALF, 6, 1, 16'h0002, 0, 32'h0000_7b2c);
	load_entry("lbu_off9", MEM_BYTE, 7, 1, 16'h0009, 0, 32'h0000_005e);
	load_entry("lbu_off3", MEM_BYTE, 3, 1, 16'h0003, 2, 32'h0000_007b);
endtask

//--- testbench/cpu_core_tb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_core_tb
	import isa_pkg::*;
	import pipe_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int KIND_WB = 1;
	localparam int KIND_BR = 2;
	localparam int KIND_ST = 4;

	logic clk;
	logic rst;
	logic instr_valid;
	logic [31:0] instr;
	logic [`CPU_XLEN-1:0] pc_plus_4;
	logic wb_valid;
	reg_idx_t wb_rd;
	logic [`CPU_XLEN-1:0] wb_val;
	logic branch_valid;
	logic branch_taken;
	logic [`CPU_XLEN-1:0] branch_target;
	logic mem_wr_en;
	logic [`CPU_XLEN-1:0] mar;
	logic [`CPU_XLEN-1:0] mdr;

	string t_name[$];
	logic [31:0] t_instr[$];
	logic [31:0] t_pc[$];
	int t_gap[$];
	int t_kind[$]; // Mask of the strobes the entry must produce.
	reg_idx_t t_rd[$];
	logic [31:0] t_val[$]; // Writeback value, or store data.
	logic t_taken[$];
	logic [31:0] t_addr[$]; // Branch target, or store address.
	int wb_q[$];
	int br_q[$];
	int st_q[$];
	int checks;
	int value_errs;
	int other_errs;
	bit table_ready;

	cpu_core i_cpu_core (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
		.pc_plus_4(pc_plus_4), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_val(wb_val),
		.branch_valid(branch_valid), .branch_taken(branch_taken),
		.branch_target(branch_target), .mem_wr_en(mem_wr_en), .mar(mar), .mdr(mdr)
	);

	function automatic logic [31:0] instr_word(logic [1:0] cls, logic [3:0] opc, int rd,
			int ra, int rb, logic use_imm, logic [15:0] imm);
		return {cls, opc, rd[2:0], ra[2:0], rb[2:0], use_imm, imm};
	endfunction

	task automatic push_entry(string name, logic [31:0] word, logic [31:0] pc, int gap,
			int kind, int rd, logic [31:0] val, logic taken, logic [31:0] addr);
		t_name.push_back(name);
		t_instr.push_back(word);
		t_pc.push_back(pc);
		t_gap.push_back(gap);
		t_kind.push_back(kind);
		t_rd.push_back(rd[2:0]);
		t_val.push_back(val);
		t_taken.push_back(taken);
		t_addr.push_back(addr);
	endtask

	task automatic arith_entry(string name, alu_opc_t opc, int rd, int ra, int rb,
			logic use_imm, logic [15:0] imm, int gap, logic [31:0] val);
		push_entry(name, instr_word(CLASS_ARITH, opc, rd, ra, rb, use_imm, imm), 32'h0, gap,
			KIND_WB, rd, val, 1'b0, 32'h0);
	endtask

	task automatic compare_entry(string name, int ra, int rb, int gap);
		push_entry(name, instr_word(CLASS_ARITH, ALU_CMP, 0, ra, rb, 1'b0, 16'h0), 32'h0, gap,
			0, 0, 32'h0, 1'b0, 32'h0); // Only the flags change.
	endtask

	task automatic branch_entry(string name, branch_cond_t cond, logic [31:0] pc,
			logic [15:0] imm, int gap, logic taken, logic [31:0] target);
		push_entry(name, instr_word(CLASS_BRANCH, {1'b0, cond}, 0, 0, 0, 1'b1, imm), pc, gap,
			KIND_BR, 0, 32'h0, taken, target);
	endtask

	task automatic call_entry(string name, int rd, logic [31:0] pc, logic [15:0] imm, int gap,
			logic [31:0] target);
		push_entry(name, instr_word(CLASS_CALL, 4'h0, rd, 0, 0, 1'b1, imm), pc, gap,
			KIND_WB | KIND_BR, rd, pc, 1'b1, target);
	endtask

	task automatic store_entry(string name, mem_width_t width, int ra, int rb,
			logic [15:0] imm, int gap, logic [31:0] addr, logic [31:0] data);
		push_entry(name, instr_word(CLASS_MEM, {2'b10, width}, 0, ra, rb, 1'b1, imm), 32'h0,
			gap, KIND_ST, 0, data, 1'b0, addr);
	endtask

	task automatic load_entry(string name, mem_width_t width, int rd, int ra,
			logic [15:0] imm, int gap, logic [31:0] val);
		push_entry(name, instr_word(CLASS_MEM, {2'b00, width}, rd, ra, 0, 1'b1, imm), 32'h0,
			gap, KIND_WB, rd, val, 1'b0, 32'h0);
	endtask

	`include "test_table.svh"

	task automatic issue(int i);
		instr_valid <= 1'b1;
		instr <= t_instr[i];
		pc_plus_4 <= t_pc[i];
		if ((t_kind[i] & KIND_WB) != 0)
			wb_q.push_back(i);
		if ((t_kind[i] & KIND_BR) != 0)
			br_q.push_back(i);
		if ((t_kind[i] & KIND_ST) != 0)
			st_q.push_back(i);
	endtask

	task automatic writeback_check;
		int i;
		assert (wb_q.size() > 0) else begin
			other_errs++;
			$display("Writeback to r%0d arrived with no instruction waiting for one", wb_rd);
		end
		if (wb_q.size() > 0) begin
			i = wb_q.pop_front();
			checks++;
			assert (wb_rd == t_rd[i] && wb_val == t_val[i]) else begin
				value_errs++;
				$display("Fail %s: expected r%0d = %h, actual r%0d = %h",
					t_name[i], t_rd[i], t_val[i], wb_rd, wb_val);
			end
		end
	endtask

	task automatic branch_check;
		int i;
		assert (br_q.size() > 0) else begin
			other_errs++;
			$display("Branch strobe arrived with no branch or call in flight");
		end
		if (br_q.size() > 0) begin
			i = br_q.pop_front();
			checks++;
			assert (branch_taken == t_taken[i] && branch_target == t_addr[i]) else begin
				value_errs++;
				$display("Fail %s: expected taken %b target %h, actual taken %b target %h",
					t_name[i], t_taken[i], t_addr[i], branch_taken, branch_target);
			end
		end
	endtask

	task automatic store_check;
		int i;
		assert (st_q.size() > 0) else begin
			other_errs++;
			$display("Memory write at %h arrived with no store in flight", mar);
		end
		if (st_q.size() > 0) begin
			i = st_q.pop_front();
			checks++;
			assert (mar == t_addr[i] && mdr == t_val[i]) else begin
				value_errs++;
				$display("Fail %s: expected mar %h mdr %h, actual mar %h mdr %h",
					t_name[i], t_addr[i], t_val[i], mar, mdr);
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		int limit;
		wait (table_ready);
		limit = 12; // Reset, idle check and drain.
		for (int i = 0; i < t_gap.size(); i++)
			limit += t_gap[i] + 8;
		repeat (limit) @(posedge clk);
		$display("Timeout: results still outstanding after %0d clock cycles", limit);
		$display("Summary: %0d checks, %0d value errors, %0d other errors",
			checks, value_errs, other_errs + 1);
		$display("Done: errors found");
		$finish;
	end

	// Outputs change on the rising edge, so they are sampled on the falling one.
	always @(negedge clk) begin
		if (!rst) begin
			if (wb_valid)
				writeback_check();
			if (branch_valid)
				branch_check();
			if (mem_wr_en)
				store_check();
		end
	end

	initial begin
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		pc_plus_4 = '0;
		load_table();
		table_ready = 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		repeat (2) @(negedge clk);
		assert (!wb_valid && !branch_valid && !mem_wr_en) else begin
			other_errs++;
			$display("A strobe was raised in the idle cycles after reset");
		end
		for (int i = 0; i < t_instr.size(); i++) begin
			@(posedge clk);
			issue(i);
			repeat (t_gap[i]) begin
				@(posedge clk);
				instr_valid <= 1'b0;
			end
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		while (wb_q.size() + br_q.size() + st_q.size() > 0)
			@(posedge clk);
		repeat (4) @(posedge clk); // Any late strobe shows up as unexpected.
		$display("Summary: %0d checks, %0d value errors, %0d other errors",
			checks, value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- verilog/cpu_core.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_core
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 instr_valid,
	input  logic [31:0]          instr,
	input  logic [`CPU_XLEN-1:0] pc_plus_4,
	output logic                 wb_valid,
	output reg_idx_t             wb_rd,
	output logic [`CPU_XLEN-1:0] wb_val,
	output logic                 branch_valid,
	output logic                 branch_taken,
	output logic [`CPU_XLEN-1:0] branch_target,
	output logic                 mem_wr_en,
	output logic [`CPU_XLEN-1:0] mar,
	output logic [`CPU_XLEN-1:0] mdr
);

	reg_idx_t ra_idx;
	reg_idx_t rb_idx;
	logic [`CPU_XLEN-1:0] ra_data;
	logic [`CPU_XLEN-1:0] rb_data;
	logic ex_valid;
	logic [`CPU_XLEN-1:0] ex_ra;
	logic [`CPU_XLEN-1:0] ex_rb;
	logic [`CPU_XLEN-1:0] ex_imm32;
	logic [`CPU_XLEN-1:0] ex_pc;
	reg_idx_t ex_rd_sel;
	logic ex_update_rd;
	alu_opc_t ex_alu_opc;
	op1_sel_t ex_op1_ra;
	op2_sel_t ex_op2_rb;
	logic ex_mem_load;
	logic ex_mem_store;
	mem_width_t ex_mem_width;
	branch_cond_t ex_cond;
	instr_class_t ex_class;
	logic ex_is_call;
	logic ex_update_flags;
	logic mw_valid;
	logic [`CPU_XLEN-1:0] mw_alu_out;
	logic mw_mem_load;
	mem_width_t mw_mem_width;
	logic [`CPU_XLEN-1:0] mw_wr_val;
	logic mw_wr_result;
	reg_idx_t mw_rd_sel;

	instr_decoder i_instr_decoder (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
		.pc_plus_4(pc_plus_4), .ra_data(ra_data), .rb_data(rb_data),
		.ra_idx(ra_idx), .rb_idx(rb_idx), .ex_valid(ex_valid), .ra(ex_ra), .rb(ex_rb),
		.imm32(ex_imm32), .pc_out(ex_pc), .rd_sel(ex_rd_sel), .update_rd(ex_update_rd),
		.alu_opc(ex_alu_opc), .alu_op1_ra(ex_op1_ra), .alu_op2_rb(ex_op2_rb),
		.mem_load(ex_mem_load), .mem_store(ex_mem_store), .mem_width(ex_mem_width),
		.branch_condition(ex_cond), .instr_class(ex_class), .is_call(ex_is_call),
		.update_flags(ex_update_flags)
	);

	reg_file i_reg_file (
		.clk(clk), .rst(rst), .ra_idx(ra_idx), .rb_idx(rb_idx),
		.wr_en(wb_valid), .wr_idx(wb_rd), .wr_data(wb_val), // Writeback commits here.
		.ra_data(ra_data), .rb_data(rb_data)
	);

	exec_unit i_exec_unit (
		.clk(clk), .rst(rst), .ex_valid(ex_valid), .ra(ex_ra), .rb(ex_rb),
		.imm32(ex_imm32), .pc_plus_4(ex_pc), .rd_sel(ex_rd_sel), .update_rd(ex_update_rd),
		.alu_opc(ex_alu_opc), .alu_op1_ra(ex_op1_ra), .alu_op2_rb(ex_op2_rb),
		.mem_load(ex_mem_load), .mem_store(ex_mem_store), .mem_width(ex_mem_width),
		.branch_condition(ex_cond), .instr_class(ex_class), .is_call(ex_is_call),
		.update_flags(ex_update_flags), .branch_valid(branch_valid),
		.branch_taken(branch_taken), .branch_target(branch_target), .mw_valid(mw_valid),
		.alu_out(mw_alu_out), .mem_load_out(mw_mem_load), .mem_store_out(),
		.mem_width_out(mw_mem_width), .wr_val(mw_wr_val), .wr_result(mw_wr_result),
		.rd_sel_out(mw_rd_sel), .mar(mar), .mdr(mdr), .mem_wr_en(mem_wr_en)
	);

	mem_writeback i_mem_writeback (
		.clk(clk), .rst(rst), .mw_valid(mw_valid), .alu_out(mw_alu_out),
		.mem_load(mw_mem_load), .mem_width(mw_mem_width), .wr_val(mw_wr_val),
		.wr_result(mw_wr_result), .rd_sel(mw_rd_sel), .mar(mar), .mdr(mdr),
		.mem_wr_en(mem_wr_en), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_val(wb_val)
	);

endmodule

//--- verilog/mem_writeback.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module mem_writeback
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 mw_valid,
	input  logic [`CPU_XLEN-1:0] alu_out,
	input  logic                 mem_load,
	input  mem_width_t           mem_width,
	input  logic [`CPU_XLEN-1:0] wr_val,
	input  logic                 wr_result,
	input  reg_idx_t             rd_sel,
	input  logic [`CPU_XLEN-1:0] mar,
	input  logic [`CPU_XLEN-1:0] mdr,
	input  logic                 mem_wr_en,
	output logic                 wb_valid,
	output reg_idx_t             wb_rd,
	output logic [`CPU_XLEN-1:0] wb_val
);

	localparam int AW = $clog2(`CPU_DMEM_WORDS);

	logic [31:0] ram [`CPU_DMEM_WORDS];
	logic [3:0] be;
	logic [31:0] wdata;
	logic [31:0] rshift;
	logic [31:0] load_data;
	logic misaligned;

	always_comb begin
		case (mem_width)
		MEM_BYTE: begin
			be = 4'b0001 << mar[1:0];
			wdata = {4{mdr[7:0]}};
		end
		MEM_HALF: begin
			be = mar[1] ? 4'b1100 : 4'b0011;
			wdata = {2{mdr[15:0]}};
		end
		default: begin
			be = 4'b1111;
			wdata = mdr;
		end
		endcase
	end

	always_ff @(posedge clk) begin
		if (mem_wr_en) begin
			for (int i = 0; i < 4; i++) begin
				if (be[i])
					ram[mar[AW+1:2]][i*8 +: 8] <= wdata[i*8 +: 8];
			end
		end
	end

	// Loads read at the ALU result, which equals mar for a load.
	assign rshift = ram[alu_out[AW+1:2]] >> {alu_out[1:0], 3'b000};
	assign load_data = (mem_width == MEM_BYTE) ? {24'b0, rshift[7:0]} :
			   (mem_width == MEM_HALF) ? {16'b0, rshift[15:0]} : rshift;

	always_ff @(posedge clk) begin
		if (rst)
			wb_valid <= 1'b0;
		else
			wb_valid <= mw_valid && wr_result;
		wb_rd <= rd_sel;
		wb_val <= mem_load ? load_data : wr_val;
	end

	assign misaligned = (mem_width == MEM_HALF && mar[0]) ||
			    (mem_width == MEM_WORD && mar[1:0] != 2'b00);

	a_aligned: assert property (@(posedge clk) disable iff (rst)
		(mem_wr_en || mem_load) |-> !misaligned);

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module reg_file
	import pipe_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  reg_idx_t             ra_idx,
	input  reg_idx_t             rb_idx,
	input  logic                 wr_en,
	input  reg_idx_t             wr_idx,
	input  logic [`CPU_XLEN-1:0] wr_data,
	output logic [`CPU_XLEN-1:0] ra_data,
	output logic [`CPU_XLEN-1:0] rb_data
);

	logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// A write in flight is forwarded to the readers.
	assign ra_data = (wr_en && wr_idx == ra_idx) ? wr_data : regs[ra_idx];
	assign rb_data = (wr_en && wr_idx == rb_idx) ? wr_data : regs[rb_idx];

endmodule
